// ==== grid_erosion_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module grid_erosion_top (
    input  logic                clock,
    input  logic                reset,

    input  logic                load_valid_i,
    input  grid_pkg::row_addr_t load_addr_i,
    input  grid_pkg::row_t      load_row_i,
    input  logic                start_i,

    output logic                busy_o,
    output logic                done_o,
    output grid_pkg::total_t    removed_total_o
);

    logic                  rd_en;
    grid_pkg::row_addr_t   rd_addr;
    grid_pkg::row_t        rd_row;
    logic                  wr_en;
    grid_pkg::row_addr_t   wr_addr;
    grid_pkg::row_t        wr_row;

    logic                  window_valid;
    grid_pkg::row_addr_t   window_addr;
    grid_pkg::row_t        row_above;
    grid_pkg::row_t        row_centre;
    grid_pkg::row_t        row_below;

    logic [grid_pkg::LANE_COUNT-1:0]                   lane_valid;
    grid_pkg::row_t                                    lane_kept;
    grid_pkg::lane_count_t [grid_pkg::LANE_COUNT-1:0]  lane_removed;

    logic                  pass_end;
    logic                  pass_changed;
    logic                  finish;

    grid_mem grid_mem_i (
        .clock        (clock),
        .reset        (reset),
        .load_valid_i (load_valid_i),
        .load_addr_i  (load_addr_i),
        .load_row_i   (load_row_i),
        .busy_i       (busy_o),
        .rd_en_i      (rd_en),
        .rd_addr_i    (rd_addr),
        .wr_en_i      (wr_en),
        .wr_addr_i    (wr_addr),
        .wr_row_i     (wr_row),
        .rd_row_o     (rd_row)
    );

    row_window_feeder row_window_feeder_i (
        .clock          (clock),
        .reset          (reset),
        .start_i        (start_i),
        .pass_end_i     (pass_end),
        .pass_changed_i (pass_changed),
        .rd_en_o        (rd_en),
        .rd_addr_o      (rd_addr),
        .rd_row_i       (rd_row),
        .window_valid_o (window_valid),
        .window_addr_o  (window_addr),
        .row_above_o    (row_above),
        .row_centre_o   (row_centre),
        .row_below_o    (row_below),
        .busy_o         (busy_o),
        .finish_o       (finish)
    );

    // ********************
    // Lanes
    // ********************
    // A zero below column 0 gives lane 0 its empty left halo and the shift
    // brings in zeros past the last column
    genvar lane_i;
    generate
        for (lane_i = 0; lane_i < grid_pkg::LANE_COUNT; lane_i++) begin : lane_gen
            roll_lane roll_lane_i (
                .clock          (clock),
                .reset          (reset),
                .window_valid_i (window_valid),
                .row_above_i    (grid_pkg::row_t'({row_above, 1'b0}
                                    >> (lane_i * grid_pkg::LANE_COLS))),
                .row_centre_i   (grid_pkg::row_t'({row_centre, 1'b0}
                                    >> (lane_i * grid_pkg::LANE_COLS))),
                .row_below_i    (grid_pkg::row_t'({row_below, 1'b0}
                                    >> (lane_i * grid_pkg::LANE_COLS))),
                .lane_valid_o   (lane_valid[lane_i]),
                .lane_kept_o    (lane_kept[lane_i*grid_pkg::LANE_COLS +: grid_pkg::LANE_COLS]),
                .lane_removed_o (lane_removed[lane_i])
            );
        end
    endgenerate

    pass_collector pass_collector_i (
        .clock           (clock),
        .reset           (reset),
        .start_i         (start_i),
        .finish_i        (finish),
        .window_addr_i   (window_addr),
        .lane_valid_i    (&lane_valid),
        .lane_kept_i     (lane_kept),
        .lane_removed_i  (lane_removed),
        .wr_en_o         (wr_en),
        .wr_addr_o       (wr_addr),
        .wr_row_o        (wr_row),
        .pass_end_o      (pass_end),
        .pass_changed_o  (pass_changed),
        .done_o          (done_o),
        .removed_total_o (removed_total_o)
    );

endmodule

`default_nettype wire

// ==== grid_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module grid_mem (
    input  logic                clock,
    input  logic                reset,

    input  logic                load_valid_i,
    input  grid_pkg::row_addr_t load_addr_i,
    input  grid_pkg::row_t      load_row_i,
    input  logic                busy_i,

    input  logic                rd_en_i,
    input  grid_pkg::row_addr_t rd_addr_i,

    input  logic                wr_en_i,
    input  grid_pkg::row_addr_t wr_addr_i,
    input  grid_pkg::row_t      wr_row_i,

    output grid_pkg::row_t      rd_row_o
);

    grid_pkg::row_t rows [grid_pkg::GRID_ROWS];

    // Host loads only land while idle and the engine only writes while busy
    always_ff @(posedge clock) begin
        if (load_valid_i && !busy_i) begin
            rows[load_addr_i] <= load_row_i;
        end else if (wr_en_i) begin
            rows[wr_addr_i] <= wr_row_i;
        end
    end

    // A read of the row being written returns the old contents
    always_ff @(posedge clock) begin
        if (reset) begin
            rd_row_o <= '0;
        end else if (rd_en_i) begin
            rd_row_o <= rows[rd_addr_i];
        end
    end

endmodule

`default_nettype wire

// ==== grid_pkg.sv ====
`default_nettype none

package grid_pkg;

    // ********************
    // Grid geometry
    // ********************
    localparam int GRID_ROWS       = 16;
    localparam int GRID_COLS       = 16;
    localparam int LANE_COUNT      = 4;
    localparam int LANE_COLS       = GRID_COLS / LANE_COUNT;
    localparam int NEIGHBOUR_LIMIT = 4;
    localparam int ROW_ADDR_W      = $clog2(GRID_ROWS);

    // A row holds one bit per column and a set bit marks a roll
    typedef logic [GRID_COLS-1:0]             row_t;
    typedef logic [ROW_ADDR_W-1:0]            row_addr_t;
    typedef logic [LANE_COLS-1:0]             lane_bits_t;
    typedef logic [$clog2(LANE_COLS+1)-1:0]   lane_count_t;
    typedef logic [15:0]                      total_t;

    localparam row_addr_t LAST_ROW = row_addr_t'(GRID_ROWS - 1);

    // ********************
    // Feeder FSM
    // ********************
    typedef enum logic [2:0] {
        FEED_IDLE,
        FEED_ABOVE,
        FEED_CENTRE,
        FEED_BELOW,
        FEED_STROBE,
        FEED_WAIT,
        FEED_FINISH
    } feeder_state_t;

endpackage

`default_nettype wire

// ==== pass_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

module pass_collector (
    input  logic                                              clock,
    input  logic                                              reset,

    input  logic                                              start_i,
    input  logic                                              finish_i,
    input  grid_pkg::row_addr_t                               window_addr_i,

    input  logic                                              lane_valid_i,
    input  grid_pkg::row_t                                    lane_kept_i,
    input  grid_pkg::lane_count_t [grid_pkg::LANE_COUNT-1:0]  lane_removed_i,

    output logic                                              wr_en_o,
    output grid_pkg::row_addr_t                               wr_addr_o,
    output grid_pkg::row_t                                    wr_row_o,

    output logic                                              pass_end_o,
    output logic                                              pass_changed_o,

    output logic                                              done_o,
    output grid_pkg::total_t                                  removed_total_o
);

    grid_pkg::row_addr_t addr_q;
    grid_pkg::total_t    row_removed;
    grid_pkg::total_t    total_q;
    logic                changed_q;
    logic                running_q;
    logic                last_row;

    always_comb begin
        row_removed = '0;
        for (int k = 0; k < grid_pkg::LANE_COUNT; k++) begin
            row_removed = row_removed + grid_pkg::total_t'(lane_removed_i[k]);
        end
    end

    // Window address lines up with the lane results one cycle later
    always_ff @(posedge clock) begin
        addr_q <= window_addr_i;
    end

    assign last_row = (addr_q == grid_pkg::LAST_ROW);

    // ********************
    // Pass and run control
    // ********************
    always_ff @(posedge clock) begin
        if (reset) begin
            wr_en_o         <= 1'b0;
            pass_end_o      <= 1'b0;
            done_o          <= 1'b0;
            changed_q       <= 1'b0;
            running_q       <= 1'b0;
            total_q         <= '0;
            removed_total_o <= '0;
        end else begin
            wr_en_o    <= lane_valid_i;
            pass_end_o <= lane_valid_i && last_row;
            done_o     <= 1'b0;
            if (start_i && !running_q) begin
                running_q       <= 1'b1;
                changed_q       <= 1'b0;
                total_q         <= '0;
                removed_total_o <= '0;
            end else if (finish_i) begin
                running_q       <= 1'b0;
                done_o          <= 1'b1;
                removed_total_o <= total_q;
            end else if (lane_valid_i) begin
                total_q   <= total_q + row_removed;
                changed_q <= !last_row && (changed_q || (row_removed != '0));
            end
        end
    end

    always_ff @(posedge clock) begin
        if (lane_valid_i) begin
            wr_addr_o      <= addr_q;
            wr_row_o       <= lane_kept_i;
            pass_changed_o <= changed_q || (row_removed != '0);
        end
    end

endmodule

`default_nettype wire

// ==== roll_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module roll_lane (
    input  logic                  clock,
    input  logic                  reset,

    input  logic                  window_valid_i,
    input  grid_pkg::row_t        row_above_i,
    input  grid_pkg::row_t        row_centre_i,
    input  grid_pkg::row_t        row_below_i,

    output logic                  lane_valid_o,
    output grid_pkg::lane_bits_t  lane_kept_o,
    output grid_pkg::lane_count_t lane_removed_o
);

    grid_pkg::lane_bits_t  kept_next;
    grid_pkg::lane_count_t removed_next;

    // The rows come in shifted so this lane's columns start at bit 1
    // and bits 0 and LANE_COLS+1 hold the neighbouring columns
    always_comb begin
        logic [3:0] neigh_count;
        kept_next    = '0;
        removed_next = '0;
        for (int j = 0; j < grid_pkg::LANE_COLS; j++) begin
            neigh_count = 4'(row_above_i[j])  + 4'(row_above_i[j+1])  + 4'(row_above_i[j+2])
                        + 4'(row_centre_i[j]) + 4'(row_centre_i[j+2])
                        + 4'(row_below_i[j])  + 4'(row_below_i[j+1])  + 4'(row_below_i[j+2]);
            if (row_centre_i[j+1]) begin
                if (neigh_count >= grid_pkg::NEIGHBOUR_LIMIT) begin
                    kept_next[j] = 1'b1;
                end else begin
                    removed_next = removed_next + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            lane_valid_o <= 1'b0;
        end else begin
            lane_valid_o <= window_valid_i;
        end
    end

    always_ff @(posedge clock) begin
        if (window_valid_i) begin
            lane_kept_o    <= kept_next;
            lane_removed_o <= removed_next;
        end
    end

endmodule

`default_nettype wire

// ==== row_window_feeder.sv ====
`timescale 1ns/1ps
`default_nettype none

module row_window_feeder (
    input  logic                clock,
    input  logic                reset,

    input  logic                start_i,
    input  logic                pass_end_i,
    input  logic                pass_changed_i,

    output logic                rd_en_o,
    output grid_pkg::row_addr_t rd_addr_o,
    input  grid_pkg::row_t      rd_row_i,

    output logic                window_valid_o,
    output grid_pkg::row_addr_t window_addr_o,
    output grid_pkg::row_t      row_above_o,
    output grid_pkg::row_t      row_centre_o,
    output grid_pkg::row_t      row_below_o,

    output logic                busy_o,
    output logic                finish_o
);

    grid_pkg::feeder_state_t state;
    grid_pkg::row_addr_t     row_q;

    assign busy_o   = (state != grid_pkg::FEED_IDLE);
    assign finish_o = (state == grid_pkg::FEED_FINISH);

    // Rows outside the grid are never read
    always_comb begin
        rd_en_o   = 1'b0;
        rd_addr_o = row_q;
        case (state)
            grid_pkg::FEED_ABOVE: begin
                rd_en_o   = (row_q != '0);
                rd_addr_o = row_q - 1'b1;
            end
            grid_pkg::FEED_CENTRE: begin
                rd_en_o = 1'b1;
            end
            grid_pkg::FEED_BELOW: begin
                rd_en_o   = (row_q != grid_pkg::LAST_ROW);
                rd_addr_o = row_q + 1'b1;
            end
            default: begin
                rd_en_o = 1'b0;
            end
        endcase
    end

    // ********************
    // Pass sequencing
    // ********************
    always_ff @(posedge clock) begin
        if (reset) begin
            state          <= grid_pkg::FEED_IDLE;
            row_q          <= '0;
            window_valid_o <= 1'b0;
        end else begin
            window_valid_o <= (state == grid_pkg::FEED_STROBE);
            case (state)
                grid_pkg::FEED_IDLE: begin
                    if (start_i) begin
                        row_q <= '0;
                        state <= grid_pkg::FEED_ABOVE;
                    end
                end
                grid_pkg::FEED_ABOVE:  state <= grid_pkg::FEED_CENTRE;
                grid_pkg::FEED_CENTRE: state <= grid_pkg::FEED_BELOW;
                grid_pkg::FEED_BELOW:  state <= grid_pkg::FEED_STROBE;
                grid_pkg::FEED_STROBE: begin
                    if (row_q == grid_pkg::LAST_ROW) begin
                        state <= grid_pkg::FEED_WAIT;
                    end else begin
                        row_q <= row_q + 1'b1;
                        state <= grid_pkg::FEED_ABOVE;
                    end
                end
                // The last write lands with pass_end so the next pass reads fresh rows
                grid_pkg::FEED_WAIT: begin
                    if (pass_end_i) begin
                        row_q <= '0;
                        state <= pass_changed_i ? grid_pkg::FEED_ABOVE : grid_pkg::FEED_FINISH;
                    end
                end
                default: state <= grid_pkg::FEED_IDLE;
            endcase
        end
    end

    // Each read returns in the state after it was issued
    always_ff @(posedge clock) begin
        if (state == grid_pkg::FEED_CENTRE) begin
            row_above_o <= (row_q == '0) ? '0 : rd_row_i;
        end
        if (state == grid_pkg::FEED_BELOW) begin
            row_centre_o <= rd_row_i;
        end
        if (state == grid_pkg::FEED_STROBE) begin
            row_below_o   <= (row_q == grid_pkg::LAST_ROW) ? '0 : rd_row_i;
            window_addr_o <= row_q;
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the grid erosion testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_grid_erosion -o tb_grid_erosion
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_grid_erosion)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test OK"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== tb_grid_erosion.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_grid_erosion;

    localparam int KIND_EMPTY    = 0;
    localparam int KIND_ISOLATED = 1;
    localparam int KIND_CHECKER  = 2;
    localparam int KIND_FULL     = 3;
    localparam int KIND_RANDOM   = 4;
    // Runs again on whatever the previous test left in the grid
    localparam int KIND_KEEP     = 5;

    localparam int N_TESTS      = 9;
    localparam int PASS_CYCLES  = 70;
    localparam int MAX_PASSES   = 17;
    localparam int DONE_TIMEOUT = MAX_PASSES * PASS_CYCLES;
    localparam longint WATCHDOG_NS =
        longint'(N_TESTS * (grid_pkg::GRID_ROWS + DONE_TIMEOUT) + 20) * 40;

    typedef struct packed {
        logic [2:0] kind;
        logic [4:0] density;
        logic [7:0] seed;
        logic       busy_load;
    } test_entry_t;

    // Density counts out of 16 and only random grids use it
    localparam test_entry_t TESTS [N_TESTS] = '{
        '{3'(KIND_EMPTY),    5'd0,  8'd0, 1'b0},
        '{3'(KIND_ISOLATED), 5'd0,  8'd0, 1'b0},
        '{3'(KIND_CHECKER),  5'd0,  8'd0, 1'b0},
        '{3'(KIND_FULL),     5'd0,  8'd0, 1'b0},
        '{3'(KIND_RANDOM),   5'd9,  8'd1, 1'b1},
        '{3'(KIND_KEEP),     5'd0,  8'd0, 1'b0},
        '{3'(KIND_RANDOM),   5'd12, 8'd2, 1'b0},
        '{3'(KIND_RANDOM),   5'd14, 8'd3, 1'b0},
        '{3'(KIND_RANDOM),   5'd7,  8'd4, 1'b0}
    };

    logic                clock = 1'b0;
    logic                reset;
    logic                load_valid_i;
    grid_pkg::row_addr_t load_addr_i;
    grid_pkg::row_t      load_row_i;
    logic                start_i;
    logic                busy_o;
    logic                done_o;
    grid_pkg::total_t    removed_total_o;

    grid_pkg::row_t model_grid [grid_pkg::GRID_ROWS];
    logic [31:0]    rng;
    int             errors;
    int             passed;
    int             failed;
    logic           timed_out;

    grid_erosion_top grid_erosion_top_i (
        .clock           (clock),
        .reset           (reset),
        .load_valid_i    (load_valid_i),
        .load_addr_i     (load_addr_i),
        .load_row_i      (load_row_i),
        .start_i         (start_i),
        .busy_o          (busy_o),
        .done_o          (done_o),
        .removed_total_o (removed_total_o)
    );

    always #20 clock = ~clock;

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int neighbour_count(int r, int c);
        int count;
        count = 0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                if ((dr != 0 || dc != 0) && r + dr >= 0 && r + dr < grid_pkg::GRID_ROWS
                    && c + dc >= 0 && c + dc < grid_pkg::GRID_COLS) begin
                    count += int'(model_grid[r+dr][c+dc]);
                end
            end
        end
        return count;
    endfunction

    function automatic int count_rolls();
        int count;
        count = 0;
        for (int r = 0; r < grid_pkg::GRID_ROWS; r++) begin
            count += $countones(model_grid[r]);
        end
        return count;
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("error at %0d ns: %s", $time, msg);
    endtask

    task automatic build_grid(input test_entry_t t);
        rng = 32'd55463 ^ {24'd0, t.seed};
        for (int r = 0; r < grid_pkg::GRID_ROWS; r++) begin
            for (int c = 0; c < grid_pkg::GRID_COLS; c++) begin
                case (int'(t.kind))
                    KIND_EMPTY:    model_grid[r][c] = 1'b0;
                    KIND_ISOLATED: model_grid[r][c] = (r % 2 == 0) && (c % 2 == 0);
                    KIND_CHECKER:  model_grid[r][c] = ((r + c) % 2 == 0);
                    KIND_FULL:     model_grid[r][c] = 1'b1;
                    default: begin
                        rng = xorshift(rng);
                        model_grid[r][c] = ({1'b0, rng[3:0]} < t.density);
                    end
                endcase
            end
        end
    endtask

    // Strict passes from a snapshot settle on the same rolls as in-place updates
    task automatic model_erode(output int removed);
        grid_pkg::row_t next_grid [grid_pkg::GRID_ROWS];
        int             pass_removed;
        removed = 0;
        do begin
            pass_removed = 0;
            for (int r = 0; r < grid_pkg::GRID_ROWS; r++) begin
                next_grid[r] = model_grid[r];
                for (int c = 0; c < grid_pkg::GRID_COLS; c++) begin
                    if (model_grid[r][c] && neighbour_count(r, c) < grid_pkg::NEIGHBOUR_LIMIT) begin
                        next_grid[r][c] = 1'b0;
                        pass_removed++;
                    end
                end
            end
            for (int r = 0; r < grid_pkg::GRID_ROWS; r++) begin
                model_grid[r] = next_grid[r];
            end
            removed += pass_removed;
        end while (pass_removed != 0);
    endtask

    task automatic load_grid();
        for (int r = 0; r < grid_pkg::GRID_ROWS; r++) begin
            @(posedge clock);
            load_valid_i <= 1'b1;
            load_addr_i  <= grid_pkg::row_addr_t'(r);
            load_row_i   <= model_grid[r];
        end
        @(posedge clock);
        load_valid_i <= 1'b0;
    endtask

    task automatic run_engine(input logic busy_load, output grid_pkg::total_t total,
                              output logic got_done);
        int   cycles;
        logic busy_seen_low;
        got_done      = 1'b0;
        busy_seen_low = 1'b0;
        cycles        = 0;
        total         = '0;
        @(posedge clock);
        start_i <= 1'b1;
        while (!got_done && cycles < DONE_TIMEOUT) begin
            @(posedge clock);
            start_i      <= 1'b0;
            // A full row aimed at row 5 while busy has to be dropped by the memory
            load_valid_i <= busy_load && (cycles == 3);
            load_addr_i  <= grid_pkg::row_addr_t'(5);
            load_row_i   <= '1;
            @(negedge clock);
            if (done_o) begin
                got_done = 1'b1;
                total    = removed_total_o;
            end else if (!busy_o && !busy_seen_low) begin
                busy_seen_low = 1'b1;
                flag_error($sformatf("busy_o low %0d cycles after start, before done_o", cycles));
            end
            cycles++;
        end
    endtask

    initial begin
        grid_pkg::total_t got_total;
        logic             got_done;
        int               expected;
        int               loaded;
        int               errors_before;
        reset        = 1'b1;
        load_valid_i = 1'b0;
        load_addr_i  = '0;
        load_row_i   = '0;
        start_i      = 1'b0;
        errors       = 0;
        passed       = 0;
        failed       = 0;
        timed_out    = 1'b0;
        for (int r = 0; r < grid_pkg::GRID_ROWS; r++) begin
            model_grid[r] = '0;
        end

        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        if (busy_o || done_o || removed_total_o != '0) begin
            flag_error($sformatf("after reset busy %0b done %0b total %0d, expected 0 0 0",
                                 busy_o, done_o, removed_total_o));
        end

        // ********************
        // Table loop
        // ********************
        for (int t = 0; t < N_TESTS && !timed_out; t++) begin
            errors_before = errors;
            if (int'(TESTS[t].kind) != KIND_KEEP) begin
                build_grid(TESTS[t]);
                load_grid();
            end
            loaded = count_rolls();
            model_erode(expected);
            run_engine(TESTS[t].busy_load, got_total, got_done);
            if (!got_done) begin
                $display("timeout: test %0d saw no done_o within %0d cycles", t, DONE_TIMEOUT);
                timed_out = 1'b1;
            end else begin
                if (got_total != grid_pkg::total_t'(expected)) begin
                    flag_error($sformatf("test %0d total expected %0d, got %0d",
                                         t, expected, got_total));
                end
                if ((int'(TESTS[t].kind) == KIND_ISOLATED || int'(TESTS[t].kind) == KIND_CHECKER)
                    && got_total != grid_pkg::total_t'(loaded)) begin
                    flag_error($sformatf("test %0d expected all %0d rolls removed, got %0d",
                                         t, loaded, got_total));
                end
                @(negedge clock);
                if (done_o || busy_o) begin
                    flag_error($sformatf("test %0d one cycle after done, done %0b busy %0b",
                                         t, done_o, busy_o));
                end
                if (removed_total_o != got_total) begin
                    flag_error($sformatf("test %0d total moved from %0d to %0d after done",
                                         t, got_total, removed_total_o));
                end
            end
            if (got_done && errors == errors_before) begin
                passed++;
            end else begin
                failed++;
            end
            $display("test %0d kind %0d: removed %0d, expected %0d, %s", t, TESTS[t].kind,
                     got_total, expected, (got_done && errors == errors_before) ? "passed"
                                                                               : "failed");
        end

        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 passed + failed, passed, failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
grid_pkg.sv
grid_mem.sv
row_window_feeder.sv
roll_lane.sv
pass_collector.sv
grid_erosion_top.sv
tb_grid_erosion.sv
